// ==== filelist.f ====
src/link_pkg.sv
src/byte_fifo.sv
src/laser_tx_serializer.sv
src/laser_rx_deserializer.sv
src/header_detector.sv
src/link_ctrl.sv
src/laser_drop.sv
bench/laser_drop_props.sv
bench/laser_drop_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the laser_drop testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module laser_drop_tb \
    -f filelist.f -o sim_laser_drop > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_laser_drop > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== bench/laser_drop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_drop_tb;
    import link_pkg::*;

    localparam int FRAME_CYCLES = FRAME_BITS * CLKS_PER_BIT;
    localparam int WAIT_LIMIT = 8000;
    localparam int SILENCE_CYCLES = TIMEOUT_CYCLES + 100;
    // longest high run inside back-to-back handshake frames is about two bits
    localparam int IDLE_RUN = 3 * CLKS_PER_BIT;

    logic  clock;
    logic  reset;
    logic  in_write;
    byte_t in_data;
    logic  in_full;
    logic  out_read;
    byte_t out_data;
    logic  out_empty;
    logic  laser_rx;
    logic  laser_tx;

    // far-side view of laser_tx and the expected receive queue contents
    byte_t seen [$];
    byte_t expected [$];
    logic  dec_active;
    int    dec_cnt;
    int    dec_bit;
    byte_t dec_byte;

    laser_drop laser_drop_i (
        .clock, .reset,
        .in_write, .in_data, .in_full,
        .out_read, .out_data, .out_empty,
        .laser_rx, .laser_tx
    );

    always #10 clock = ~clock;

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(string name, logic [31:0] exp_val, logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("** Error: %s expected %0h actual %0h", name, exp_val, act_val);
            fail_run();
        end
    endtask

    // far-side decoder, samples laser_tx near the middle of each bit
    always @(negedge clock) begin
        if (reset) begin
            dec_active = 1'b0;
            dec_cnt = 0;
        end else if (!dec_active) begin
            if (laser_tx == 1'b0) begin
                dec_active = 1'b1;
                dec_cnt = 0;
            end
        end else begin
            dec_cnt = dec_cnt + 1;
            if (dec_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                dec_bit = dec_cnt / CLKS_PER_BIT;
                if (dec_bit == 0) begin
                    // a glitch, not a start bit
                    dec_active = !laser_tx;
                end else if (dec_bit < FRAME_BITS - 1) begin
                    dec_byte = {laser_tx, dec_byte[7:1]};
                end else if (!laser_tx) begin
                    $display("stop bit on laser_tx was low, frame is broken");
                    fail_run();
                end else begin
                    dec_active = 1'b0;
                    seen.push_back(dec_byte);
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // far-side sender, start bit, data lsb first, stop bit
    task automatic send_frame(byte_t value);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            laser_rx = bits[i];
            repeat (CLKS_PER_BIT) next_cycle();
        end
    endtask

    task automatic host_write(byte_t value);
        check("in_full before write", 0, in_full);
        in_write = 1'b1;
        in_data = value;
        next_cycle();
        in_write = 1'b0;
    endtask

    task automatic read_and_compare(string name, byte_t exp_val);
        int waited;
        waited = 0;
        while (out_empty) begin
            if (waited == WAIT_LIMIT) begin
                $display("no byte arrived in the receive queue during %s", name);
                fail_run();
            end else begin
                next_cycle();
                waited++;
            end
        end
        check(name, exp_val, out_data);
        out_read = 1'b1;
        next_cycle();
        out_read = 1'b0;
    endtask

    task automatic wait_for_seen(int count, string name);
        int waited;
        waited = 0;
        while (seen.size() < count) begin
            if (waited == WAIT_LIMIT) begin
                $display("laser_tx carried fewer than %0d frames during %s", count, name);
                fail_run();
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic wait_for_idle_line(string name);
        int waited;
        int high_run;
        waited = 0;
        high_run = 0;
        while (high_run < IDLE_RUN) begin
            if (waited == WAIT_LIMIT) begin
                $display("laser_tx never went idle during %s", name);
                fail_run();
            end else begin
                high_run = laser_tx ? high_run + 1 : 0;
                next_cycle();
                waited++;
            end
        end
    endtask

    // neither a handshake nor the first byte of any header
    function automatic byte_t plain_byte();
        byte_t value;
        value = byte_t'($urandom);
        if (value == HS_BYTE || value == START_HDR[31:24] || value == STOP_HDR[31:24]
                || value == DATA_HDR[31:24]) begin
            value = value ^ 8'h01;
        end
        return value;
    endfunction

    task automatic receive_packet(string name, int payload_len);
        hdr_t  hdr;
        byte_t value;
        expected.delete();
        case ($urandom % 3)
            0: hdr = START_HDR;
            1: hdr = STOP_HDR;
            default: hdr = DATA_HDR;
        endcase
        for (int i = 3; i >= 0; i--) begin
            expected.push_back(hdr[8 * i +: 8]);
            send_frame(hdr[8 * i +: 8]);
        end
        for (int i = 0; i < payload_len; i++) begin
            value = plain_byte();
            // header counts toward the packet length
            if (expected.size() < PKT_LEN) begin
                expected.push_back(value);
            end
            send_frame(value);
        end
        repeat (SILENCE_CYCLES) next_cycle();
        for (int i = 0; i < expected.size(); i++) begin
            read_and_compare(name, expected[i]);
        end
        check({name, " queue empty after drain"}, 1, out_empty);
    endtask

    initial begin
        int    n;
        int    hs_count;
        byte_t data_bytes [$];
        void'($urandom(32'h2240_2133));
        clock = 1'b0;
        reset = 1'b1;
        in_write = 1'b0;
        in_data = '0;
        out_read = 1'b0;
        laser_rx = 1'b1;
        repeat (3) next_cycle();
        reset = 1'b0;
        next_cycle();

        check("reset laser_tx", 1, laser_tx);
        check("reset out_empty", 1, out_empty);
        check("reset in_full", 0, in_full);

        // far side opens a handshake
        seen.delete();
        send_frame(HS_BYTE);
        wait_for_seen(1, "handshake reply");
        check("handshake reply", HS_REPLY_BYTE, seen[0]);
        repeat (SILENCE_CYCLES) next_cycle();
        check("handshake reply count", 1, seen.size());

        // host burst behind a handshake
        seen.delete();
        n = 1 + int'($urandom % 20);
        for (int i = 0; i < n; i++) begin
            data_bytes.push_back(byte_t'($urandom));
            host_write(data_bytes[i]);
        end
        wait_for_seen(1, "handshake start");
        check("handshake byte", HS_BYTE, seen[0]);
        send_frame(HS_REPLY_BYTE);
        wait_for_idle_line("alignment gap");
        hs_count = seen.size();
        for (int i = 0; i < hs_count; i++) begin
            check("handshake repeat", HS_BYTE, seen[i]);
        end
        wait_for_seen(hs_count + n, "transmit burst");
        for (int i = 0; i < n; i++) begin
            check("burst byte", data_bytes[i], seen[hs_count + i]);
        end
        repeat (4 * FRAME_CYCLES) next_cycle();
        check("burst length", hs_count + n, seen.size());
        check("line idle after burst", 1, laser_tx);

        receive_packet("packet receive", 1 + int'($urandom % 40));
        receive_packet("second packet", 1 + int'($urandom % 40));

        // noise with the DUT idle
        seen.delete();
        n = 5 + int'($urandom % 11);
        for (int i = 0; i < n; i++) begin
            send_frame(plain_byte());
        end
        repeat (SILENCE_CYCLES) next_cycle();
        check("noise leaves queue empty", 1, out_empty);
        check("noise draws no reply", 0, seen.size());

        receive_packet("length cap", 80);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/laser_drop_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_drop_props (
    input logic clock,
    input logic reset,
    input logic tx_start,
    input logic tx_busy,
    input logic laser_tx,
    input logic rq_push,
    input logic rq_full,
    input logic out_empty,
    input logic in_full
);

    // serializer takes a frame only when idle
    tx_start_when_free: assert property (
        @(posedge clock) disable iff (reset) tx_start |-> !tx_busy
    ) else $error("tx_start raised while the serializer was busy");

    line_high_when_idle: assert property (
        @(posedge clock) disable iff (reset) !tx_busy |-> laser_tx
    ) else $error("laser_tx low while the serializer was idle");

    no_push_when_full: assert property (
        @(posedge clock) disable iff (reset) rq_push |-> !rq_full
    ) else $error("receive queue pushed while full");

    // queues come out of reset empty
    queues_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (out_empty && !in_full)
    ) else $error("queue flags wrong in the cycle after reset");

endmodule

bind laser_drop laser_drop_props laser_drop_props_i (
    .clock(clock),
    .reset(reset),
    .tx_start(tx_start),
    .tx_busy(tx_busy),
    .laser_tx(laser_tx),
    .rq_push(rq_push),
    .rq_full(rq_full),
    .out_empty(out_empty),
    .in_full(in_full)
);

`default_nettype wire

// ==== src/laser_drop.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_drop (
    input  logic            clock,
    input  logic            reset,
    input  logic            in_write,
    input  link_pkg::byte_t in_data,
    output logic            in_full,
    input  logic            out_read,
    output link_pkg::byte_t out_data,
    output logic            out_empty,
    input  logic            laser_rx,
    output logic            laser_tx
);
    import link_pkg::*;

    byte_t    tq_data;
    logic     tq_empty;
    logic     tq_pop;
    byte_t    rq_byte;
    logic     rq_push;
    logic     rq_full;
    byte_t    tx_byte;
    logic     tx_start;
    logic     tx_busy;
    logic     tx_done;
    byte_t    rx_byte;
    logic     rx_valid;
    logic     hdr_seen;
    hdr_sel_t hdr_sel;

    // host to laser
    byte_fifo tx_queue_i (
        .clock, .reset,
        .push(in_write), .push_data(in_data),
        .pop(tq_pop), .pop_data(tq_data),
        .empty(tq_empty), .full(in_full)
    );

    // laser to host
    byte_fifo rx_queue_i (
        .clock, .reset,
        .push(rq_push), .push_data(rq_byte),
        .pop(out_read), .pop_data(out_data),
        .empty(out_empty), .full(rq_full)
    );

    laser_tx_serializer tx_serializer_i (
        .clock, .reset,
        .tx_start, .tx_byte,
        .laser_tx, .tx_busy, .tx_done
    );

    laser_rx_deserializer rx_deserializer_i (
        .clock, .reset,
        .laser_rx, .rx_valid, .rx_byte
    );

    header_detector header_detector_i (
        .clock, .reset,
        .rx_valid, .rx_byte,
        .hdr_seen, .hdr_sel
    );

    link_ctrl link_ctrl_i (
        .clock, .reset,
        .rx_valid, .rx_byte,
        .hdr_seen, .hdr_sel,
        .tq_data, .tq_empty, .tq_pop,
        .tx_busy, .tx_done, .tx_start, .tx_byte,
        .rq_full, .rq_push, .rq_byte
    );

endmodule

`default_nettype wire

// ==== src/link_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_ctrl (
    input  logic               clock,
    input  logic               reset,
    input  logic               rx_valid,
    input  link_pkg::byte_t    rx_byte,
    input  logic               hdr_seen,
    input  link_pkg::hdr_sel_t hdr_sel,
    input  link_pkg::byte_t    tq_data,
    input  logic               tq_empty,
    output logic               tq_pop,
    input  logic               tx_busy,
    input  logic               tx_done,
    output logic               tx_start,
    output link_pkg::byte_t    tx_byte,
    input  logic               rq_full,
    output logic               rq_push,
    output link_pkg::byte_t    rq_byte
);
    import link_pkg::*;

    typedef enum logic [2:0] {
        S_WAIT,
        S_HS_TX,
        S_HS_DRAIN,
        S_ALIGN,
        S_SEND,
        S_HS_REPLY,
        S_HDR_LOAD,
        S_RECEIVE
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [CNT_W-1:0] timer;
    logic [CNT_W-1:0] byte_cnt;
    hdr_sel_t         sel_q;
    logic             reply_pend;
    logic             hs_seen;
    logic             reply_seen;
    logic             timed_out;

    assign hs_seen = rx_valid && (rx_byte == HS_BYTE);
    assign reply_seen = rx_valid && (rx_byte == HS_REPLY_BYTE);
    assign timed_out = (timer == CNT_W'(TIMEOUT_CYCLES - 1)) && !rx_valid;

    always_comb begin
        next_state = state;
        tx_start = 1'b0;
        tx_byte = HS_BYTE;
        tq_pop = 1'b0;
        rq_push = 1'b0;
        rq_byte = rx_byte;
        case (state)
            S_WAIT: begin
                if (!tq_empty) begin
                    next_state = S_HS_TX;
                end else if (hs_seen) begin
                    next_state = S_HS_REPLY;
                end else if (hdr_seen) begin
                    next_state = S_HDR_LOAD;
                end
            end
            S_HS_TX: begin
                // keep repeating the handshake until answered
                tx_start = !tx_busy;
                if (reply_seen) begin
                    next_state = S_HS_DRAIN;
                end
            end
            S_HS_DRAIN: begin
                if (tx_done || !tx_busy) begin
                    next_state = S_ALIGN;
                end
            end
            S_ALIGN: begin
                if (timer == CNT_W'(ALIGN_CYCLES - 1)) begin
                    next_state = S_SEND;
                end
            end
            S_SEND: begin
                tx_byte = tq_data;
                if (!tx_busy) begin
                    if (tq_empty) begin
                        next_state = S_WAIT;
                    end else begin
                        tx_start = 1'b1;
                        tq_pop = 1'b1;
                    end
                end
            end
            S_HS_REPLY: begin
                tx_byte = HS_REPLY_BYTE;
                tx_start = reply_pend && !tx_busy;
                if (hdr_seen) begin
                    next_state = S_HDR_LOAD;
                end else if (timed_out) begin
                    next_state = S_WAIT;
                end
            end
            S_HDR_LOAD: begin
                // header rebuilt from the matched index
                rq_byte = hdr_byte(sel_q, byte_cnt[1:0]);
                if (!rq_full) begin
                    rq_push = 1'b1;
                    if (byte_cnt[1:0] == 2'd3) begin
                        next_state = S_RECEIVE;
                    end
                end
            end
            default: begin
                rq_push = rx_valid && !rq_full && (byte_cnt != CNT_W'(PKT_LEN));
                if (byte_cnt == CNT_W'(PKT_LEN) || timed_out) begin
                    next_state = S_WAIT;
                end
            end
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= S_WAIT;
            timer <= '0;
            byte_cnt <= '0;
            reply_pend <= 1'b0;
        end else begin
            state <= next_state;

            // align gap ignores line activity, idle timeouts do not
            if (next_state != state) begin
                timer <= '0;
            end else if (rx_valid && state != S_ALIGN) begin
                timer <= '0;
            end else begin
                timer <= timer + 1'b1;
            end

            // header bytes count toward the packet length
            if (state != S_HDR_LOAD && state != S_RECEIVE) begin
                byte_cnt <= '0;
            end else if ((state == S_HDR_LOAD) ? rq_push : rx_valid) begin
                byte_cnt <= byte_cnt + 1'b1;
            end

            if (hs_seen && next_state == S_HS_REPLY) begin
                reply_pend <= 1'b1;
            end else if (tx_start || next_state != S_HS_REPLY) begin
                reply_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hdr_seen) begin
            sel_q <= hdr_sel;
        end
    end

endmodule

`default_nettype wire

// ==== src/header_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_detector (
    input  logic               clock,
    input  logic               reset,
    input  logic               rx_valid,
    input  link_pkg::byte_t    rx_byte,
    output logic               hdr_seen,
    output link_pkg::hdr_sel_t hdr_sel
);
    import link_pkg::*;

    hdr_sel_t   sel_q;
    hdr_sel_t   first_sel;
    logic       first_hit;
    logic       next_hit;
    // header bytes matched so far
    logic [1:0] matched;

    // first bytes of all headers differ, so at most one hit
    always_comb begin
        first_hit = 1'b0;
        first_sel = '0;
        for (int i = 0; i < NUM_HDRS; i++) begin
            if (rx_byte == hdr_byte(hdr_sel_t'(i), 2'd0)) begin
                first_hit = 1'b1;
                first_sel = hdr_sel_t'(i);
            end
        end
    end

    assign next_hit = (rx_byte == hdr_byte(sel_q, matched));
    assign hdr_seen = rx_valid && (matched == 2'd3) && next_hit;
    assign hdr_sel = sel_q;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            matched <= '0;
            sel_q <= '0;
        end else if (rx_valid) begin
            if (matched == 2'd0) begin
                if (first_hit) begin
                    sel_q <= first_sel;
                    matched <= 2'd1;
                end
            end else if (next_hit) begin
                // wraps back to searching after the fourth byte
                matched <= matched + 2'd1;
            end else begin
                // mismatching byte is not tried as a new first byte
                matched <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/laser_rx_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_rx_deserializer (
    input  logic            clock,
    input  logic            reset,
    input  logic            laser_rx,
    output logic            rx_valid,
    output link_pkg::byte_t rx_byte
);
    import link_pkg::*;

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // line idles high
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= laser_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= R_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                R_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= R_START;
                    end
                end
                R_START: begin
                    // start bit must still be low at half a bit
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_sync ? R_IDLE : R_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                R_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= R_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    // framing error drops the byte
                    if (bit_end) begin
                        rx_valid <= rx_sync;
                        state <= R_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == R_DATA && bit_end) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== src/laser_tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_tx_serializer (
    input  logic            clock,
    input  logic            reset,
    input  logic            tx_start,
    input  link_pkg::byte_t tx_byte,
    output logic            laser_tx,
    output logic            tx_busy,
    output logic            tx_done
);
    import link_pkg::*;

    logic [FRAME_BITS-1:0] frame;
    logic [CNT_W-1:0]      bit_time;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  bit_end;

    assign bit_end = tx_busy && (bit_time == CNT_W'(CLKS_PER_BIT - 1));
    // last cycle of the stop bit
    assign tx_done = bit_end && (bit_cnt == CNT_W'(FRAME_BITS - 1));
    assign laser_tx = tx_busy ? frame[0] : 1'b1;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            tx_busy <= 1'b0;
            bit_time <= '0;
            bit_cnt <= '0;
        end else if (tx_start && !tx_busy) begin
            tx_busy <= 1'b1;
            bit_time <= '0;
            bit_cnt <= '0;
        end else if (tx_done) begin
            tx_busy <= 1'b0;
        end else if (bit_end) begin
            bit_time <= '0;
            bit_cnt <= bit_cnt + 1'b1;
        end else if (tx_busy) begin
            bit_time <= bit_time + 1'b1;
        end
    end

    // stop bit, data lsb first, start bit
    always_ff @(posedge clock) begin
        if (tx_start && !tx_busy) begin
            frame <= {1'b1, tx_byte, 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = link_pkg::QUEUE_DEPTH
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            push,
    input  link_pkg::byte_t push_data,
    input  logic            pop,
    output link_pkg::byte_t pop_data,
    output logic            empty,
    output logic            full
);
    import link_pkg::*;

    byte_t                  mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign empty = (count == '0);
    assign full = (count == DEPTH);
    // show-ahead, front byte always on the output
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/link_pkg.sv ====
`default_nettype none

package link_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [31:0] hdr_t;
    // 0 start, 1 stop, 2 data
    typedef logic [1:0] hdr_sel_t;

    // packet headers, most significant byte first on the line
    localparam hdr_t START_HDR = 32'hc1c2c3c4;
    localparam hdr_t STOP_HDR = 32'h51525354;
    localparam hdr_t DATA_HDR = 32'hd1d2d3d4;
    localparam int NUM_HDRS = 3;

    localparam byte_t HS_BYTE = 8'haa;
    localparam byte_t HS_REPLY_BYTE = 8'h10;

    // line timing in clock cycles
    localparam int CLKS_PER_BIT = 12;
    localparam int FRAME_BITS = 10;
    localparam int ALIGN_CYCLES = 16 * CLKS_PER_BIT;

    localparam int PKT_LEN = 64;
    localparam int TIMEOUT_CYCLES = 1024;
    localparam int QUEUE_DEPTH = 128;
    localparam int CNT_W = 12;

    // byte idx of header sel, idx 0 is the first byte sent
    function automatic byte_t hdr_byte(hdr_sel_t sel, logic [1:0] idx);
        hdr_t hdr;
        case (sel)
            2'd1: hdr = STOP_HDR;
            2'd2: hdr = DATA_HDR;
            default: hdr = START_HDR;
        endcase
        return hdr[8 * (3 - idx) +: 8];
    endfunction

endpackage

`default_nettype wire
